//--- pipe_pkg.sv
// shared widths, opcodes and enums for the four-stage alu pipeline, imported by every stage
package pipe_pkg;

	// data and address widths
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;

	// alu operation picked in decode
	typedef enum logic [3:0] {
		alu_add  = 4'h0,
		alu_sub  = 4'h1,
		alu_and  = 4'h2,
		alu_or   = 4'h3,
		alu_xor  = 4'h4,
		alu_sll  = 4'h5,
		alu_srl  = 4'h6,
		alu_sra  = 4'h7,
		alu_slt  = 4'h8,
		alu_sltu = 4'h9
	} alu_func_t;

	// second alu operand source
	typedef enum logic {
		opb_is_rs2 = 1'b0,
		opb_is_imm = 1'b1
	} opb_sel_t;

	// pipeline status seen at the top level
	typedef enum logic [1:0] {
		no_error      = 2'h0,
		halted_on_wfi = 2'h1,
		illegal_inst  = 2'h2
	} exc_code_t;

	// rv32i major opcodes handled here
	localparam logic [6:0] opc_alu_reg = 7'b0110011;
	localparam logic [6:0] opc_alu_imm = 7'b0010011;
	localparam logic [6:0] opc_lui     = 7'b0110111;

	// funct7 patterns for base and alternate ops
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	// the one system encoding that is accepted
	localparam inst_t wfi_inst = 32'h1050_0073;

endpackage

//--- pipe_ifc.sv
// stage-to-stage buses: issue_bus from dispatch to execute, done_bus from execute to retire

// decoded instruction with its register operands
interface issue_bus;
	import pipe_pkg::*;

	logic      valid;
	addr_t     pc;
	alu_func_t func;
	opb_sel_t  opb_sel;
	word_t     imm;
	reg_idx_t  rs1_idx;
	reg_idx_t  rs2_idx;
	word_t     rs1_value;
	word_t     rs2_value;
	reg_idx_t  dest_idx;
	logic      halt;
	logic      illegal;

	modport dispatch (
		output valid, pc, func, opb_sel, imm, rs1_idx, rs2_idx,
		output rs1_value, rs2_value, dest_idx, halt, illegal
	);

	modport exec (
		input valid, pc, func, opb_sel, imm, rs1_idx, rs2_idx,
		input rs1_value, rs2_value, dest_idx, halt, illegal
	);
endinterface

// finished alu result on its way to retire
interface done_bus;
	import pipe_pkg::*;

	logic     valid;
	addr_t    pc;
	reg_idx_t dest_idx;
	word_t    result;
	logic     halt;
	logic     illegal;

	modport exec (output valid, pc, dest_idx, result, halt, illegal);
	modport retire (input valid, pc, dest_idx, result, halt, illegal);
	// read-back used by execute for forwarding
	modport monitor (input valid, dest_idx, result);
endinterface

//--- fetch_stage.sv
// fetch stage: drives the instruction address and tags the word that memory returns next cycle
module fetch_stage #(
	parameter pipe_pkg::addr_t reset_pc = '0
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            stop,
	output pipe_pkg::addr_t proc2mem_addr,
	output logic            fetch_valid,
	output pipe_pkg::addr_t fetch_pc
);
	import pipe_pkg::*;

	addr_t pc;
	logic  stopped;
	logic  hold;

	// freeze as soon as decode sees wfi or a bad word
	assign hold = stop || stopped;

	// address goes straight out of the pc register
	assign proc2mem_addr = pc;

	always_ff @(posedge clock) begin
		if (reset) begin
			pc          <= reset_pc;
			stopped     <= 1'b0;
			fetch_valid <= 1'b0;
		end else begin
			pc          <= hold ? pc : pc + addr_t'(4);
			// sticky until the next reset
			stopped     <= hold;
			// word arriving next cycle is only good while running
			fetch_valid <= !hold;
		end
	end

	// address of the word now on mem2proc_data
	always_ff @(posedge clock) begin
		fetch_pc <= pc;
	end

endmodule

//--- dispatch_stage.sv
// dispatch stage: decodes the fetched word, reads both sources and fills the issue register
module dispatch_stage (
	input  logic               clock,
	input  logic               reset,
	input  logic               fetch_valid,
	input  pipe_pkg::addr_t    fetch_pc,
	input  pipe_pkg::inst_t    mem2proc_data,
	output logic               stop,
	output pipe_pkg::reg_idx_t rd_idx_a,
	output pipe_pkg::reg_idx_t rd_idx_b,
	input  pipe_pkg::word_t    rd_value_a,
	input  pipe_pkg::word_t    rd_value_b,
	issue_bus.dispatch         issue
);
	import pipe_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	alu_func_t  dec_func;
	opb_sel_t   dec_opb_sel;
	word_t      dec_imm;
	logic       dec_halt;
	logic       dec_illegal;
	logic       is_lui;

	assign opcode = mem2proc_data[6:0];
	assign funct3 = mem2proc_data[14:12];
	assign funct7 = mem2proc_data[31:25];

	////////////////////////////////////////////////////////////
	// decoder
	////////////////////////////////////////////////////////////

	always_comb begin
		dec_func    = alu_add;
		dec_opb_sel = opb_is_rs2;
		// i-type immediate unless lui overrides
		dec_imm     = {{20{mem2proc_data[31]}}, mem2proc_data[31:20]};
		dec_halt    = 1'b0;
		dec_illegal = 1'b0;
		is_lui      = 1'b0;
		case (opcode)
			opc_alu_reg: begin
				case ({funct7, funct3})
					{f7_base, 3'b000}: dec_func = alu_add;
					{f7_alt,  3'b000}: dec_func = alu_sub;
					{f7_base, 3'b001}: dec_func = alu_sll;
					{f7_base, 3'b010}: dec_func = alu_slt;
					{f7_base, 3'b011}: dec_func = alu_sltu;
					{f7_base, 3'b100}: dec_func = alu_xor;
					{f7_base, 3'b101}: dec_func = alu_srl;
					{f7_alt,  3'b101}: dec_func = alu_sra;
					{f7_base, 3'b110}: dec_func = alu_or;
					{f7_base, 3'b111}: dec_func = alu_and;
					default:           dec_illegal = 1'b1;
				endcase
			end
			opc_alu_imm: begin
				dec_opb_sel = opb_is_imm;
				case (funct3)
					3'b000: dec_func = alu_add;
					3'b010: dec_func = alu_slt;
					3'b011: dec_func = alu_sltu;
					3'b100: dec_func = alu_xor;
					3'b110: dec_func = alu_or;
					3'b111: dec_func = alu_and;
					3'b001: begin
						dec_func    = alu_sll;
						dec_illegal = (funct7 != f7_base);
					end
					3'b101: begin
						// upper bits pick logical or arithmetic
						if (funct7 == f7_base)
							dec_func = alu_srl;
						else if (funct7 == f7_alt)
							dec_func = alu_sra;
						else
							dec_illegal = 1'b1;
					end
				endcase
			end
			opc_lui: begin
				// lui is x0 + upper immediate
				dec_opb_sel = opb_is_imm;
				dec_imm     = {mem2proc_data[31:12], 12'b0};
				is_lui      = 1'b1;
			end
			default: begin
				if (mem2proc_data == wfi_inst)
					dec_halt = 1'b1;
				else
					dec_illegal = 1'b1;
			end
		endcase
	end

	// tells fetch to freeze
	assign stop = fetch_valid && (dec_halt || dec_illegal);

	// lui reads x0 so no forwarding can hit its operand a
	assign rd_idx_a = is_lui ? reg_idx_t'(0) : mem2proc_data[19:15];
	assign rd_idx_b = mem2proc_data[24:20];

	////////////////////////////////////////////////////////////
	// issue register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			issue.valid   <= 1'b0;
			issue.halt    <= 1'b0;
			issue.illegal <= 1'b0;
		end else begin
			issue.valid   <= fetch_valid;
			issue.halt    <= fetch_valid && dec_halt;
			issue.illegal <= fetch_valid && dec_illegal;
		end
	end

	always_ff @(posedge clock) begin
		issue.pc        <= fetch_pc;
		issue.func      <= dec_func;
		issue.opb_sel   <= dec_opb_sel;
		issue.imm       <= dec_imm;
		issue.rs1_idx   <= rd_idx_a;
		issue.rs2_idx   <= rd_idx_b;
		issue.rs1_value <= rd_value_a;
		issue.rs2_value <= rd_value_b;
		// x0 kept here, retire drops the write
		issue.dest_idx  <= mem2proc_data[11:7];
	end

	// wfi and illegal are separate stop causes
	halt_excl_illegal: assert property (@(posedge clock) disable iff (reset)
		!(issue.halt && issue.illegal));

endmodule

//--- regfile.sv
// integer register file: two combinational read ports and one write port from retire
module regfile (
	input  logic               clock,
	input  logic               reset,
	input  pipe_pkg::reg_idx_t rd_idx_a,
	input  pipe_pkg::reg_idx_t rd_idx_b,
	output pipe_pkg::word_t    rd_value_a,
	output pipe_pkg::word_t    rd_value_b,
	input  logic               wr_en,
	input  pipe_pkg::reg_idx_t wr_idx,
	input  pipe_pkg::word_t    wr_data
);
	import pipe_pkg::*;

	// x1 to x31, x0 has no storage
	word_t regs [31:1];

	// x0 reads as zero
	assign rd_value_a = (rd_idx_a == '0) ? word_t'(0) : regs[rd_idx_a];
	assign rd_value_b = (rd_idx_b == '0) ? word_t'(0) : regs[rd_idx_b];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data;
		end
	end

endmodule

//--- exec_stage.sv
// execute stage: forwards operands from done_bus and the commit port, runs the alu, fills done
module exec_stage (
	input  logic               clock,
	input  logic               reset,
	issue_bus.exec             issue,
	done_bus.exec              done,
	done_bus.monitor           done_fwd,
	input  logic               commit_wr_en,
	input  pipe_pkg::reg_idx_t commit_wr_idx,
	input  pipe_pkg::word_t    commit_wr_data
);
	import pipe_pkg::*;

	word_t      opa;
	word_t      opb_reg;
	word_t      opb;
	word_t      alu_result;
	logic [4:0] shamt;
	logic       last_en;

	// previous instruction counts only with a real destination
	assign last_en = done_fwd.valid && (done_fwd.dest_idx != '0);

	// newest producer wins, then commit, then the value read in dispatch
	function automatic word_t fwd_operand(
		input reg_idx_t idx,
		input word_t    rf_value,
		input logic     l_en,
		input reg_idx_t l_idx,
		input word_t    l_data,
		input logic     c_en,
		input reg_idx_t c_idx,
		input word_t    c_data
	);
		if (l_en && (idx == l_idx))
			return l_data;
		if (c_en && (idx == c_idx))
			return c_data;
		return rf_value;
	endfunction

	////////////////////////////////////////////////////////////
	// operands
	////////////////////////////////////////////////////////////

	assign opa = fwd_operand(issue.rs1_idx, issue.rs1_value, last_en, done_fwd.dest_idx,
		done_fwd.result, commit_wr_en, commit_wr_idx, commit_wr_data);
	assign opb_reg = fwd_operand(issue.rs2_idx, issue.rs2_value, last_en, done_fwd.dest_idx,
		done_fwd.result, commit_wr_en, commit_wr_idx, commit_wr_data);
	assign opb = (issue.opb_sel == opb_is_imm) ? issue.imm : opb_reg;

	// shifts use the low five bits only
	assign shamt = opb[4:0];

	////////////////////////////////////////////////////////////
	// alu
	////////////////////////////////////////////////////////////

	always_comb begin
		case (issue.func)
			alu_add:  alu_result = opa + opb;
			alu_sub:  alu_result = opa - opb;
			alu_and:  alu_result = opa & opb;
			alu_or:   alu_result = opa | opb;
			alu_xor:  alu_result = opa ^ opb;
			alu_sll:  alu_result = opa << shamt;
			alu_srl:  alu_result = opa >> shamt;
			alu_sra:  alu_result = word_t'($signed(opa) >>> shamt);
			alu_slt:  alu_result = word_t'($signed(opa) < $signed(opb));
			alu_sltu: alu_result = word_t'(opa < opb);
			default:  alu_result = opa + opb;
		endcase
	end

	// done register
	always_ff @(posedge clock) begin
		if (reset) begin
			done.valid   <= 1'b0;
			done.halt    <= 1'b0;
			done.illegal <= 1'b0;
		end else begin
			done.valid   <= issue.valid;
			done.halt    <= issue.halt;
			done.illegal <= issue.illegal;
		end
	end

	always_ff @(posedge clock) begin
		done.pc       <= issue.pc;
		done.dest_idx <= issue.dest_idx;
		done.result   <= alu_result;
	end

	// no stale result leaks out of reset into retire
	done_idle_after_reset: assert property (@(posedge clock) reset |=> !done.valid);

endmodule

//--- retire_stage.sv
// retire stage: writes the register file, registers the commit outputs and holds the stop status
module retire_stage (
	input  logic                clock,
	input  logic                reset,
	done_bus.retire             done,
	output logic                wr_en,
	output pipe_pkg::reg_idx_t  wr_idx,
	output pipe_pkg::word_t     wr_data,
	output logic                commit_valid,
	output logic                commit_wr_en,
	output pipe_pkg::reg_idx_t  commit_wr_idx,
	output pipe_pkg::word_t     commit_wr_data,
	output pipe_pkg::addr_t     commit_pc,
	output pipe_pkg::exc_code_t error_status
);
	import pipe_pkg::*;

	logic halted;
	logic accept;
	logic commit_halt;
	logic commit_illegal;

	// nothing is taken once a stop has retired
	assign accept = done.valid && !halted;

	// only legal ops with a real destination write
	assign wr_en   = accept && !done.halt && !done.illegal && (done.dest_idx != '0);
	assign wr_idx  = done.dest_idx;
	assign wr_data = done.result;

	always_ff @(posedge clock) begin
		if (reset) begin
			halted         <= 1'b0;
			commit_valid   <= 1'b0;
			commit_wr_en   <= 1'b0;
			commit_halt    <= 1'b0;
			commit_illegal <= 1'b0;
			error_status   <= no_error;
		end else begin
			halted         <= halted || (accept && (done.halt || done.illegal));
			commit_valid   <= accept;
			commit_wr_en   <= wr_en;
			commit_halt    <= accept && done.halt;
			commit_illegal <= accept && done.illegal;
			// status follows the stopping commit by one cycle
			if (commit_illegal)
				error_status <= illegal_inst;
			else if (commit_halt)
				error_status <= halted_on_wfi;
		end
	end

	always_ff @(posedge clock) begin
		commit_wr_idx  <= done.dest_idx;
		commit_wr_data <= done.result;
		commit_pc      <= done.pc;
	end

	// once stopped the commit stream stays quiet
	no_commit_after_stop: assert property (@(posedge clock) disable iff (reset)
		(error_status != no_error) |-> !commit_valid);

endmodule

//--- pipeline.sv
// top level of the four-stage alu pipeline, plain ports to instruction memory and commit
module pipeline #(
	parameter pipe_pkg::addr_t reset_pc = '0
) (
	input  logic                clock,
	input  logic                reset,
	input  pipe_pkg::inst_t     mem2proc_data,
	output pipe_pkg::addr_t     proc2mem_addr,
	output logic                commit_valid,
	output logic                commit_wr_en,
	output pipe_pkg::reg_idx_t  commit_wr_idx,
	output pipe_pkg::word_t     commit_wr_data,
	output pipe_pkg::addr_t     commit_pc,
	output pipe_pkg::exc_code_t error_status
);
	import pipe_pkg::*;

	// fetch to dispatch
	logic     fetch_valid;
	addr_t    fetch_pc;
	logic     stop;

	// register file reads
	reg_idx_t rd_idx_a;
	reg_idx_t rd_idx_b;
	word_t    rd_value_a;
	word_t    rd_value_b;

	// retire write port
	logic     wr_en;
	reg_idx_t wr_idx;
	word_t    wr_data;

	issue_bus issue ();
	done_bus  done ();

	////////////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////////////

	fetch_stage #(
		.reset_pc (reset_pc)
	) fetch_stage_0 (
		.clock         (clock),
		.reset         (reset),
		.stop          (stop),
		.proc2mem_addr (proc2mem_addr),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc)
	);

	dispatch_stage dispatch_stage_0 (
		.clock         (clock),
		.reset         (reset),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.mem2proc_data (mem2proc_data),
		.stop          (stop),
		.rd_idx_a      (rd_idx_a),
		.rd_idx_b      (rd_idx_b),
		.rd_value_a    (rd_value_a),
		.rd_value_b    (rd_value_b),
		.issue         (issue.dispatch)
	);

	regfile regfile_0 (
		.clock      (clock),
		.reset      (reset),
		.rd_idx_a   (rd_idx_a),
		.rd_idx_b   (rd_idx_b),
		.rd_value_a (rd_value_a),
		.rd_value_b (rd_value_b),
		.wr_en      (wr_en),
		.wr_idx     (wr_idx),
		.wr_data    (wr_data)
	);

	// commit outputs double as the older forwarding source
	exec_stage exec_stage_0 (
		.clock          (clock),
		.reset          (reset),
		.issue          (issue.exec),
		.done           (done.exec),
		.done_fwd       (done.monitor),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data)
	);

	retire_stage retire_stage_0 (
		.clock          (clock),
		.reset          (reset),
		.done           (done.retire),
		.wr_en          (wr_en),
		.wr_idx         (wr_idx),
		.wr_data        (wr_data),
		.commit_valid   (commit_valid),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data),
		.commit_pc      (commit_pc),
		.error_status   (error_status)
	);

endmodule

//--- tb_clock.sv
// testbench clock and power-on reset generator with a 100 unit period and 16 reset cycles
module tb_clock (
	output logic clock,
	output logic reset
);

	// free-running clock with 50 high and 50 low
	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	// power-on reset released on a rising edge
	initial begin
		reset <= 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- pipeline_tb.sv
// testbench for the alu pipeline with random programs, an instruction memory model and an isa model
module pipeline_tb;
	import pipe_pkg::*;

	localparam inst_t wfi_word = 32'h1050_0073;

	logic      clock;
	logic      por_reset;
	logic      test_reset = 1'b0;
	logic      reset;
	inst_t     mem2proc_data = '0;
	addr_t     proc2mem_addr;
	logic      commit_valid;
	logic      commit_wr_en;
	reg_idx_t  commit_wr_idx;
	word_t     commit_wr_data;
	addr_t     commit_pc;
	exc_code_t error_status;

	// 256-word instruction memory
	inst_t imem [0:255];

	// expected commit stream from the isa model
	addr_t     exp_pc [$];
	logic      exp_wen [$];
	reg_idx_t  exp_idx [$];
	word_t     exp_data [$];
	exc_code_t exp_status;

	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	assign reset = por_reset || test_reset;

	tb_clock clock_gen (
		.clock (clock),
		.reset (por_reset)
	);

	pipeline #(
		.reset_pc (32'h0000_0000)
	) dut (
		.clock          (clock),
		.reset          (reset),
		.mem2proc_data  (mem2proc_data),
		.proc2mem_addr  (proc2mem_addr),
		.commit_valid   (commit_valid),
		.commit_wr_en   (commit_wr_en),
		.commit_wr_idx  (commit_wr_idx),
		.commit_wr_data (commit_wr_data),
		.commit_pc      (commit_pc),
		.error_status   (error_status)
	);

	// memory answers one cycle after the address
	always @(posedge clock) begin
		mem2proc_data <= imem[proc2mem_addr[9:2]];
	end

	////////////////////////////////////////////////////////////
	// program generation
	////////////////////////////////////////////////////////////

	// one random alu or lui word with registers limited to x0..x7
	function automatic inst_t random_alu_word(input logic x0_heavy);
		int unsigned kind;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [11:0] imm;
		logic [19:0] upper;
		inst_t       w;
		kind = $urandom_range(19, 0);
		rd = 5'($urandom_range(7, 0));
		rs1 = 5'($urandom_range(7, 0));
		rs2 = 5'($urandom_range(7, 0));
		imm = 12'($urandom);
		upper = 20'($urandom);
		// x0 as target about half the time
		if (x0_heavy) begin
			if ($urandom_range(1, 0) == 0)
				rd = 5'd0;
			if ($urandom_range(3, 0) == 0)
				rs1 = 5'd0;
		end
		case (kind)
			0:  w = {7'h00, rs2, rs1, 3'd0, rd, 7'b0110011};
			1:  w = {7'h20, rs2, rs1, 3'd0, rd, 7'b0110011};
			2:  w = {7'h00, rs2, rs1, 3'd1, rd, 7'b0110011};
			3:  w = {7'h00, rs2, rs1, 3'd2, rd, 7'b0110011};
			4:  w = {7'h00, rs2, rs1, 3'd3, rd, 7'b0110011};
			5:  w = {7'h00, rs2, rs1, 3'd4, rd, 7'b0110011};
			6:  w = {7'h00, rs2, rs1, 3'd5, rd, 7'b0110011};
			7:  w = {7'h20, rs2, rs1, 3'd5, rd, 7'b0110011};
			8:  w = {7'h00, rs2, rs1, 3'd6, rd, 7'b0110011};
			9:  w = {7'h00, rs2, rs1, 3'd7, rd, 7'b0110011};
			10: w = {imm, rs1, 3'd0, rd, 7'b0010011};
			11: w = {imm, rs1, 3'd2, rd, 7'b0010011};
			12: w = {imm, rs1, 3'd3, rd, 7'b0010011};
			13: w = {imm, rs1, 3'd4, rd, 7'b0010011};
			14: w = {imm, rs1, 3'd6, rd, 7'b0010011};
			15: w = {imm, rs1, 3'd7, rd, 7'b0010011};
			// immediate shifts take shamt from the low immediate bits
			16: w = {7'h00, imm[4:0], rs1, 3'd1, rd, 7'b0010011};
			17: w = {7'h00, imm[4:0], rs1, 3'd5, rd, 7'b0010011};
			18: w = {7'h20, imm[4:0], rs1, 3'd5, rd, 7'b0010011};
			default: w = {upper, rd, 7'b0110111};
		endcase
		return w;
	endfunction

	// custom-0 opcode outside the supported subset
	function automatic inst_t undefined_word();
		inst_t w;
		w = $urandom;
		w[6:0] = 7'b0001011;
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// isa reference model
	////////////////////////////////////////////////////////////

	// rv32i alu semantics that return 0 for an encoding outside the subset
	function automatic logic reference_alu(input inst_t w, input word_t a, input word_t b,
		output word_t value);
		word_t      imm;
		logic [4:0] sh;
		logic       ok;
		imm = {{20{w[31]}}, w[31:20]};
		sh = w[24:20];
		ok = 1'b1;
		value = '0;
		case (w[6:0])
			7'b0110011: begin
				case ({w[31:25], w[14:12]})
					10'b0000000_000: value = a + b;
					10'b0100000_000: value = a - b;
					10'b0000000_001: value = a << b[4:0];
					10'b0000000_010: value = {31'b0, $signed(a) < $signed(b)};
					10'b0000000_011: value = {31'b0, a < b};
					10'b0000000_100: value = a ^ b;
					10'b0000000_101: value = a >> b[4:0];
					10'b0100000_101: value = $signed(a) >>> b[4:0];
					10'b0000000_110: value = a | b;
					10'b0000000_111: value = a & b;
					default:         ok = 1'b0;
				endcase
			end
			7'b0010011: begin
				case (w[14:12])
					3'b000: value = a + imm;
					3'b010: value = {31'b0, $signed(a) < $signed(imm)};
					// sltiu compares against the sign-extended immediate
					3'b011: value = {31'b0, a < imm};
					3'b100: value = a ^ imm;
					3'b110: value = a | imm;
					3'b111: value = a & imm;
					3'b001: begin
						value = a << sh;
						ok = (w[31:25] == 7'b0000000);
					end
					default: begin
						if (w[31:25] == 7'b0000000)
							value = a >> sh;
						else if (w[31:25] == 7'b0100000)
							value = $signed(a) >>> sh;
						else
							ok = 1'b0;
					end
				endcase
			end
			7'b0110111: value = {w[31:12], 12'b0};
			default:    ok = 1'b0;
		endcase
		return ok;
	endfunction

	// runs imem in order from address 0 and queues every commit
	task automatic build_expected();
		word_t regs [32];
		addr_t pc;
		inst_t w;
		word_t value;
		logic  legal;
		regs = '{default: '0};
		pc = '0;
		exp_status = no_error;
		exp_pc.delete();
		exp_wen.delete();
		exp_idx.delete();
		exp_data.delete();
		for (int n = 0; n < 256; n++) begin
			w = imem[pc[9:2]];
			legal = reference_alu(w, regs[w[19:15]], regs[w[24:20]], value);
			exp_pc.push_back(pc);
			// a stopping word commits with no write
			if (w == wfi_word || !legal) begin
				exp_wen.push_back(1'b0);
				exp_idx.push_back(5'd0);
				exp_data.push_back(word_t'(0));
				exp_status = (w == wfi_word) ? halted_on_wfi : illegal_inst;
				break;
			end
			exp_wen.push_back(w[11:7] != 5'd0);
			exp_idx.push_back(w[11:7]);
			exp_data.push_back(value);
			if (w[11:7] != 5'd0)
				regs[w[11:7]] = value;
			pc = pc + 32'd4;
		end
	endtask

	////////////////////////////////////////////////////////////
	// one test that loads, resets and follows the commit stream
	////////////////////////////////////////////////////////////

	task automatic run_program(input string name, input int length, input logic x0_heavy,
		input int bad_pos);
		int   errs_before;
		int   wait_cycles;
		logic aborted;
		errs_before = errors;
		aborted = 1'b0;
		@(posedge clock);
		test_reset <= 1'b1;
		@(posedge clock);
		// random alu words everywhere so words past the stop are valid
		for (int i = 0; i < 256; i++)
			imem[8'(i)] = random_alu_word(x0_heavy);
		if (bad_pos >= 0)
			imem[8'(bad_pos)] = undefined_word();
		imem[8'(length)] = wfi_word;
		build_expected();
		repeat (3) @(posedge clock);
		test_reset <= 1'b0;
		@(negedge clock);
		// idle state right after reset
		if (commit_valid !== 1'b0) begin
			$display("error commit_valid after reset: expected %h, got %h", 1'b0, commit_valid);
			errors++;
		end
		if (commit_wr_en !== 1'b0) begin
			$display("error commit_wr_en after reset: expected %h, got %h", 1'b0, commit_wr_en);
			errors++;
		end
		if (error_status !== no_error) begin
			$display("error error_status after reset: expected %h, got %h", no_error,
				error_status);
			errors++;
		end
		if (proc2mem_addr !== 32'h0) begin
			$display("error proc2mem_addr after reset: expected %h, got %h", 32'h0,
				proc2mem_addr);
			errors++;
		end
		// first commit four cycles in and then one per cycle
		for (int k = 0; k < exp_pc.size() && !aborted; k++) begin
			wait_cycles = 0;
			if (k > 0) begin
				@(negedge clock);
				wait_cycles = 1;
			end
			while (commit_valid !== 1'b1 && wait_cycles < 200) begin
				@(negedge clock);
				wait_cycles++;
			end
			if (commit_valid !== 1'b1) begin
				$display("timed out waiting for commit %0d of test %s", k, name);
				errors++;
				aborted = 1'b1;
			end else begin
				if (wait_cycles != ((k == 0) ? 4 : 1)) begin
					$display("commit %0d arrived %0d cycles after the previous point, not %0d",
						k, wait_cycles, (k == 0) ? 4 : 1);
					errors++;
				end
				if (commit_pc !== exp_pc[k]) begin
					$display("error commit_pc at commit %0d: expected %h, got %h", k, exp_pc[k],
						commit_pc);
					errors++;
				end
				if (commit_wr_en !== exp_wen[k]) begin
					$display("error commit_wr_en at commit %0d: expected %h, got %h", k,
						exp_wen[k], commit_wr_en);
					errors++;
				end
				if (exp_wen[k] && commit_wr_idx !== exp_idx[k]) begin
					$display("error commit_wr_idx at commit %0d: expected %h, got %h", k,
						exp_idx[k], commit_wr_idx);
					errors++;
				end
				if (exp_wen[k] && commit_wr_data !== exp_data[k]) begin
					$display("error commit_wr_data at commit %0d: expected %h, got %h", k,
						exp_data[k], commit_wr_data);
					errors++;
				end
			end
		end
		if (!aborted) begin
			// status lands one cycle after the stopping commit
			wait_cycles = 0;
			while (error_status === no_error && wait_cycles < 200) begin
				@(negedge clock);
				wait_cycles++;
			end
			if (error_status !== exp_status) begin
				$display("error error_status: expected %h, got %h", exp_status, error_status);
				errors++;
			end
			// nothing past the stop may retire
			for (int i = 0; i < 20; i++) begin
				@(negedge clock);
				if (commit_valid !== 1'b0) begin
					$display("a commit at pc %h followed the stop", commit_pc);
					errors++;
				end
			end
		end
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s passed, %0d commits", name, exp_pc.size());
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - errs_before);
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		int wait_cycles;
		void'($urandom(32'h8784_a559));
		wait_cycles = 0;
		@(negedge clock);
		while (por_reset && wait_cycles < 64) begin
			@(negedge clock);
			wait_cycles++;
		end
		if (por_reset) begin
			$display("power-on reset never released");
			errors++;
		end else begin
			run_program("random_alu", 60, 1'b0, -1);
			run_program("x0_targets", 60, 1'b1, -1);
			run_program("short_wfi", 12, 1'b0, -1);
			run_program("undefined_opcode", 60, 1'b0, int'($urandom_range(54, 3)));
			run_program("random_alu_again", 60, 1'b0, -1);
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- pipeline.f
pipe_pkg.sv
pipe_ifc.sv
fetch_stage.sv
dispatch_stage.sv
regfile.sv
exec_stage.sv
retire_stage.sv
pipeline.sv
tb_clock.sv
pipeline_tb.sv

//--- run.sh
#!/bin/sh
# build with verilator, run, and judge the result from the log
rm -f sim.log
verilator --binary --timing --assert --top-module pipeline_tb -f pipeline.f -o pipeline_sim \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/pipeline_sim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1
grep -q "ALL TESTS PASSED" sim.log || exit 1
exit 0
